// File: common/wbuf_pkg.sv
package wbuf_pkg;

  ////////////////////////////////////////////////////////////
  // word geometry
  ////////////////////////////////////////////////////////////

  // bytes per buffer word, one byte enable each
  localparam int WORD_BYTES = 8;
  // data bits per buffer word
  localparam int DATA_W = WORD_BYTES * 8;

  ////////////////////////////////////////////////////////////
  // default sizes, overridden from the top level
  ////////////////////////////////////////////////////////////

  // byte address width of the store port
  localparam int ADDR_W_DEFAULT = 32;
  // number of fully associative buffer words
  localparam int DEPTH_DEFAULT = 8;
  // number of transaction IDs on the write channel
  localparam int MAX_TX_DEFAULT = 4;

  ////////////////////////////////////////////////////////////
  // byte state
  ////////////////////////////////////////////////////////////

  // valid/dirty/in-flight combinations that a byte may take
  //   free      0/0/0  slot unused
  //   dirty     1/1/0  written, waiting to be sent
  //   inflight  1/0/1  part of an outstanding write
  //   redirty   1/1/1  written again while its write is out
  typedef enum logic [1:0] {
    BYTE_FREE     = 2'd0,
    BYTE_DIRTY    = 2'd1,
    BYTE_INFLIGHT = 2'd2,
    BYTE_REDIRTY  = 2'd3
  } byte_state_e;

endpackage

// File: hw/wbuf_rr_arbiter.sv
`timescale 1ns/100ps

module wbuf_rr_arbiter #(
  parameter int N = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic [N-1:0]         req_i,
  input  logic                 advance_i,
  output logic [$clog2(N)-1:0] idx_o,
  output logic                 valid_o
);
  localparam int IDX_W = $clog2(N);

  // last index that was taken
  logic [IDX_W-1:0] last_q;
  // offered index is frozen until taken
  logic             lock_q;
  logic [IDX_W-1:0] lock_idx_q;
  logic [IDX_W-1:0] rr_idx;

  // scan from far to near so the closest requester after last wins
  always_comb begin
    int cand;
    rr_idx = last_q;
    for (int k = N; k >= 1; k--) begin
      cand = (int'(last_q) + k) % N;
      if (req_i[cand]) rr_idx = IDX_W'(cand);
    end
  end

  assign idx_o   = lock_q ? lock_idx_q : rr_idx;
  assign valid_o = lock_q || (|req_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // start the scan at index 0
      last_q     <= IDX_W'(N - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (valid_o && advance_i) begin
      last_q <= idx_o;
      lock_q <= 1'b0;
    end else if (valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= idx_o;
    end
  end

  // users must keep a locked request up until it is taken
  a_offer_req : assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o |-> req_i[idx_o]);

endmodule

// File: hw/entry_array/wbuf_entry_array.sv
`timescale 1ns/100ps

module wbuf_entry_array #(
  parameter int ADDR_W = wbuf_pkg::ADDR_W_DEFAULT,
  parameter int DEPTH  = wbuf_pkg::DEPTH_DEFAULT,
  parameter int MAX_TX = wbuf_pkg::MAX_TX_DEFAULT
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            req_i,
  input  logic [ADDR_W-1:0]               addr_i,
  input  logic [wbuf_pkg::DATA_W-1:0]     wdata_i,
  input  logic [wbuf_pkg::WORD_BYTES-1:0] be_i,
  output logic                            gnt_o,
  input  logic                            mem_ack_i,
  input  logic                            slot_free_i,
  input  logic [$clog2(MAX_TX)-1:0]       tx_id_i,
  input  logic [$clog2(DEPTH)-1:0]        sel_idx_i,
  input  logic                            evict_i,
  input  logic [$clog2(DEPTH)-1:0]        evict_entry_i,
  input  logic [wbuf_pkg::WORD_BYTES-1:0] evict_be_i,
  output logic [DEPTH-1:0]                eligible_o,
  output logic                            send_o,
  output logic [$clog2(DEPTH)-1:0]        send_entry_o,
  output logic [wbuf_pkg::WORD_BYTES-1:0] send_be_o,
  output logic                            mem_req_o,
  output logic [ADDR_W-4:0]               mem_addr_o,
  output logic [wbuf_pkg::DATA_W-1:0]     mem_wdata_o,
  output logic [wbuf_pkg::WORD_BYTES-1:0] mem_be_o,
  output logic [$clog2(MAX_TX)-1:0]       mem_id_o,
  output logic                            empty_o
);
  import wbuf_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);
  localparam int TAG_W = ADDR_W - 3;

  // word address and payload, written only by stores
  logic [TAG_W-1:0]      tag_q  [DEPTH];
  logic [DATA_W-1:0]     data_q [DEPTH];
  // per-byte flags
  logic [WORD_BYTES-1:0] valid_q [DEPTH];
  logic [WORD_BYTES-1:0] dirty_q [DEPTH];
  logic [WORD_BYTES-1:0] infl_q  [DEPTH];
  logic [WORD_BYTES-1:0] valid_d [DEPTH];
  logic [WORD_BYTES-1:0] dirty_d [DEPTH];
  logic [WORD_BYTES-1:0] infl_d  [DEPTH];

  logic [DEPTH-1:0] entry_vld;
  logic [DEPTH-1:0] hit;
  logic [IDX_W-1:0] hit_idx;
  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] wr_idx;
  logic             full;
  logic             store;

  // dirty/in-flight pair seen as one state
  function automatic byte_state_e state_of(input logic dirty, input logic infl);
    return byte_state_e'({infl, dirty});
  endfunction

  ////////////////////////////////////////////////////////////
  // search
  ////////////////////////////////////////////////////////////

  always_comb begin
    hit_idx  = '0;
    free_idx = '0;
    for (int k = 0; k < DEPTH; k++) begin
      entry_vld[k] = |valid_q[k];
      hit[k] = entry_vld[k] && (tag_q[k] == addr_i[ADDR_W-1:3]);
      // a word may only go out once none of its bytes is in flight
      eligible_o[k] = (|dirty_q[k]) && !(|infl_q[k]);
      if (hit[k]) hit_idx = IDX_W'(k);
    end
    // downward scan leaves the lowest free entry
    for (int k = DEPTH - 1; k >= 0; k--) begin
      if (!entry_vld[k]) free_idx = IDX_W'(k);
    end
  end

  assign full    = &entry_vld;
  assign empty_o = ~(|entry_vld);
  // coalesce on hit, otherwise allocate
  assign wr_idx  = (|hit) ? hit_idx : free_idx;
  assign gnt_o   = req_i && ((|hit) || !full);
  assign store   = req_i && gnt_o;

  ////////////////////////////////////////////////////////////
  // write request
  ////////////////////////////////////////////////////////////

  assign mem_req_o    = (|eligible_o) && slot_free_i;
  assign send_o       = mem_req_o && mem_ack_i;
  assign mem_addr_o   = tag_q[sel_idx_i];
  assign mem_wdata_o  = data_q[sel_idx_i];
  // eligible word has no byte in flight, so all dirty bytes go
  assign mem_be_o     = dirty_q[sel_idx_i];
  assign mem_id_o     = tx_id_i;
  assign send_entry_o = sel_idx_i;
  assign send_be_o    = mem_be_o;

  ////////////////////////////////////////////////////////////
  // byte state update
  ////////////////////////////////////////////////////////////

  always_comb begin
    byte_state_e st;
    logic        ev;
    logic        wr;
    for (int k = 0; k < DEPTH; k++) begin
      for (int j = 0; j < WORD_BYTES; j++) begin
        st = state_of(dirty_q[k][j], infl_q[k][j]);
        ev = evict_i && (evict_entry_i == IDX_W'(k)) && evict_be_i[j];
        wr = store && (wr_idx == IDX_W'(k)) && be_i[j];
        // write returned, drop in-flight, keep only re-written bytes
        if (ev) begin
          st = (st == BYTE_REDIRTY) ? BYTE_DIRTY : BYTE_FREE;
        end
        if (send_o && (sel_idx_i == IDX_W'(k)) && send_be_o[j]) begin
          st = BYTE_INFLIGHT;
        end
        // store last, so a byte sent at this edge turns re-dirty
        if (wr) begin
          if (st == BYTE_INFLIGHT || st == BYTE_REDIRTY) begin
            st = BYTE_REDIRTY;
          end else begin
            st = BYTE_DIRTY;
          end
        end
        // valid set by a store, cleared when a clean byte returns
        valid_d[k][j] = wr || (valid_q[k][j] && !(ev && !dirty_q[k][j]));
        dirty_d[k][j] = (st == BYTE_DIRTY) || (st == BYTE_REDIRTY);
        infl_d[k][j]  = (st == BYTE_INFLIGHT) || (st == BYTE_REDIRTY);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < DEPTH; k++) begin
      if (reset_i) begin
        valid_q[k] <= '0;
        dirty_q[k] <= '0;
        infl_q[k]  <= '0;
      end else begin
        valid_q[k] <= valid_d[k];
        dirty_q[k] <= dirty_d[k];
        infl_q[k]  <= infl_d[k];
      end
    end
  end

  // merge enabled bytes into the chosen word
  always_ff @(posedge clk_i) begin
    if (store) begin
      tag_q[wr_idx] <= addr_i[ADDR_W-1:3];
      for (int j = 0; j < WORD_BYTES; j++) begin
        if (be_i[j]) data_q[wr_idx][j*8 +: 8] <= wdata_i[j*8 +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // allocation never creates a second entry for one word
  a_hit_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
    req_i |-> $onehot0(hit));

  // a waiting request keeps its word and ID (arbiter and ID lock)
  a_req_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_id_o));

  for (genvar k = 0; k < DEPTH; k++) begin : g_chk_entry
    for (genvar j = 0; j < WORD_BYTES; j++) begin : g_chk_byte
      a_byte_valid : assert property (@(posedge clk_i) disable iff (reset_i)
        state_of(dirty_q[k][j], infl_q[k][j]) != BYTE_FREE |-> valid_q[k][j]);
    end
  end

endmodule

// File: hw/wbuf_tx_tracker.sv
`timescale 1ns/100ps

module wbuf_tx_tracker #(
  parameter int DEPTH  = wbuf_pkg::DEPTH_DEFAULT,
  parameter int MAX_TX = wbuf_pkg::MAX_TX_DEFAULT
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            send_i,
  input  logic [$clog2(DEPTH)-1:0]        send_entry_i,
  input  logic [wbuf_pkg::WORD_BYTES-1:0] send_be_i,
  input  logic                            mem_rtrn_vld_i,
  input  logic [$clog2(MAX_TX)-1:0]       mem_rtrn_id_i,
  output logic                            slot_free_o,
  output logic [$clog2(MAX_TX)-1:0]       tx_id_o,
  output logic                            evict_o,
  output logic [$clog2(DEPTH)-1:0]        evict_entry_o,
  output logic [wbuf_pkg::WORD_BYTES-1:0] evict_be_o
);
  import wbuf_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);
  localparam int ID_W  = $clog2(MAX_TX);
  localparam int CNT_W = $clog2(MAX_TX + 1);

  // one slot per ID
  logic [MAX_TX-1:0]     slot_vld_q;
  logic [IDX_W-1:0]      slot_entry_q [MAX_TX];
  logic [WORD_BYTES-1:0] slot_be_q    [MAX_TX];

  // return ID queue, never deeper than the outstanding count
  logic [ID_W-1:0]       rtrn_mem_q [MAX_TX];
  logic [ID_W-1:0]       wr_ptr_q;
  logic [ID_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]      cnt_q;
  logic [ID_W-1:0]       rtrn_id;

  function automatic logic [ID_W-1:0] ptr_inc(input logic [ID_W-1:0] ptr);
    return (int'(ptr) == MAX_TX - 1) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // ID allocation
  ////////////////////////////////////////////////////////////

  wbuf_rr_arbiter #(
    .N (MAX_TX)
  ) i_id_arb (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (~slot_vld_q),
    .advance_i (send_i),
    .idx_o     (tx_id_o),
    .valid_o   (slot_free_o)
  );

  ////////////////////////////////////////////////////////////
  // return queue and eviction
  ////////////////////////////////////////////////////////////

  // one pop per cycle while anything is queued
  assign evict_o       = (cnt_q != '0);
  assign rtrn_id       = rtrn_mem_q[rd_ptr_q];
  assign evict_entry_o = slot_entry_q[rtrn_id];
  assign evict_be_o    = slot_be_q[rtrn_id];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_vld_q <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      cnt_q      <= '0;
    end else begin
      if (mem_rtrn_vld_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (evict_o) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({mem_rtrn_vld_i, evict_o})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
      if (evict_o) slot_vld_q[rtrn_id] <= 1'b0;
      if (send_i) slot_vld_q[tx_id_o] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rtrn_vld_i) rtrn_mem_q[wr_ptr_q] <= mem_rtrn_id_i;
    // remember where the bytes came from
    if (send_i) begin
      slot_entry_q[tx_id_o] <= send_entry_i;
      slot_be_q[tx_id_o]    <= send_be_i;
    end
  end

  // only outstanding IDs come back from memory
  a_evict_vld : assert property (@(posedge clk_i) disable iff (reset_i)
    evict_o |-> slot_vld_q[rtrn_id]);

  a_alloc_free : assert property (@(posedge clk_i) disable iff (reset_i)
    send_i && evict_o |-> tx_id_o != rtrn_id);

endmodule

// File: hw/wbuf_top.sv
`timescale 1ns/100ps

module wbuf_top #(
  parameter int ADDR_W = wbuf_pkg::ADDR_W_DEFAULT,
  parameter int DEPTH  = wbuf_pkg::DEPTH_DEFAULT,
  parameter int MAX_TX = wbuf_pkg::MAX_TX_DEFAULT
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // core store port
  input  logic                            req_i,
  input  logic [ADDR_W-1:0]               addr_i,
  input  logic [wbuf_pkg::DATA_W-1:0]     wdata_i,
  input  logic [wbuf_pkg::WORD_BYTES-1:0] be_i,
  output logic                            gnt_o,
  // memory write channel
  output logic                            mem_req_o,
  input  logic                            mem_ack_i,
  output logic [ADDR_W-4:0]               mem_addr_o,
  output logic [wbuf_pkg::DATA_W-1:0]     mem_wdata_o,
  output logic [wbuf_pkg::WORD_BYTES-1:0] mem_be_o,
  output logic [$clog2(MAX_TX)-1:0]       mem_id_o,
  // write returns
  input  logic                            mem_rtrn_vld_i,
  input  logic [$clog2(MAX_TX)-1:0]       mem_rtrn_id_i,
  // status
  output logic                            empty_o
);
  import wbuf_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);
  localparam int ID_W  = $clog2(MAX_TX);

  // entries that hold dirty bytes and nothing in flight
  logic [DEPTH-1:0]      eligible;
  // entry offered by the dirty-word arbiter, held until sent
  logic [IDX_W-1:0]      sel_idx;

  // send strobe and what went out with it
  logic                  send;
  logic [IDX_W-1:0]      send_entry;
  logic [WORD_BYTES-1:0] send_be;

  // tracker side
  logic                  slot_free;
  logic [ID_W-1:0]       tx_id;
  logic                  evict;
  logic [IDX_W-1:0]      evict_entry;
  logic [WORD_BYTES-1:0] evict_be;

  ////////////////////////////////////////////////////////////
  // storage, coalescing and the write request
  ////////////////////////////////////////////////////////////

  wbuf_entry_array #(
    .ADDR_W (ADDR_W),
    .DEPTH  (DEPTH),
    .MAX_TX (MAX_TX)
  ) i_entry_array (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .be_i          (be_i),
    .gnt_o         (gnt_o),
    .mem_ack_i     (mem_ack_i),
    .slot_free_i   (slot_free),
    .tx_id_i       (tx_id),
    .sel_idx_i     (sel_idx),
    .evict_i       (evict),
    .evict_entry_i (evict_entry),
    .evict_be_i    (evict_be),
    .eligible_o    (eligible),
    .send_o        (send),
    .send_entry_o  (send_entry),
    .send_be_o     (send_be),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_be_o      (mem_be_o),
    .mem_id_o      (mem_id_o),
    .empty_o       (empty_o)
  );

  // entries compete for the single write channel
  wbuf_rr_arbiter #(
    .N (DEPTH)
  ) i_dirty_arb (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (eligible),
    .advance_i (send),
    .idx_o     (sel_idx),
    .valid_o   ()
  );

  ////////////////////////////////////////////////////////////
  // transaction IDs and eviction on return
  ////////////////////////////////////////////////////////////

  wbuf_tx_tracker #(
    .DEPTH  (DEPTH),
    .MAX_TX (MAX_TX)
  ) i_tx_tracker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .send_i         (send),
    .send_entry_i   (send_entry),
    .send_be_i      (send_be),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .mem_rtrn_id_i  (mem_rtrn_id_i),
    .slot_free_o    (slot_free),
    .tx_id_o        (tx_id),
    .evict_o        (evict),
    .evict_entry_o  (evict_entry),
    .evict_be_o     (evict_be)
  );

endmodule

// File: verif/tb_wbuf_model.svh
`ifndef TB_WBUF_MODEL_SVH
`define TB_WBUF_MODEL_SVH

////////////////////////////////////////////////////////////
// reference state
////////////////////////////////////////////////////////////

// latest granted value of every byte in the word window
logic [7:0] latest_q  [WORDS][WORD_BYTES];
bit         written_q [WORDS][WORD_BYTES];
// bytes as memory received them
logic [7:0] image_q   [WORDS][WORD_BYTES];
// outstanding IDs, their word and cycles left until return
bit         out_vld   [MAX_TX];
int         out_word  [MAX_TX];
int         out_due   [MAX_TX];
int         out_cnt;
int         tx_cnt;

// granted store, enabled bytes only
task automatic store_bytes(input int widx, input logic [DATA_W-1:0] data,
                           input logic [WORD_BYTES-1:0] be);
  for (int j = 0; j < WORD_BYTES; j++) begin
    if (be[j]) begin
      latest_q[widx][j]  = data[j*8 +: 8];
      written_q[widx][j] = 1'b1;
    end
  end
endtask

// accepted write lands in the image, ID becomes busy
task automatic open_tx(input int id, input int widx, input logic [DATA_W-1:0] data,
                       input logic [WORD_BYTES-1:0] be, input int delay);
  for (int j = 0; j < WORD_BYTES; j++) begin
    if (be[j]) image_q[widx][j] = data[j*8 +: 8];
  end
  out_vld[id]  = 1'b1;
  out_word[id] = widx;
  out_due[id]  = delay;
  out_cnt++;
  tx_cnt++;
endtask

task automatic close_tx(input int id);
  out_vld[id] = 1'b0;
  out_cnt--;
endtask

// true while some ID still carries this word
function automatic bit word_busy(input int widx);
  for (int k = 0; k < MAX_TX; k++) begin
    if (out_vld[k] && out_word[k] == widx) return 1'b1;
  end
  return 1'b0;
endfunction

`endif

// File: verif/tb_wbuf.sv
`timescale 1ns/100ps

module tb_wbuf;
  import wbuf_pkg::*;

  localparam int ADDR_W    = 32;
  localparam int DEPTH     = 8;
  localparam int MAX_TX    = 4;
  localparam int ID_W      = $clog2(MAX_TX);
  // 12 words, more than the buffer can hold at once
  localparam int WORDS     = 12;
  localparam int BASE_WORD = 'h1200;
  localparam int RESET_CYC = 10;
  localparam int RAND_CYC  = 500;
  // reset, coalescing, back-pressure and random stimulus
  localparam int STIM_CYC    = RESET_CYC + WORD_BYTES + 1 + DEPTH + 2 + RAND_CYC;
  localparam int CYCLE_LIMIT = 4 * STIM_CYC;
  // taps 32 22 2 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                  clk_i;
  logic                  reset_i;
  logic                  req_i;
  logic [ADDR_W-1:0]     addr_i;
  logic [DATA_W-1:0]     wdata_i;
  logic [WORD_BYTES-1:0] be_i;
  logic                  gnt_o;
  logic                  mem_req_o;
  logic                  mem_ack_i;
  logic [ADDR_W-4:0]     mem_addr_o;
  logic [DATA_W-1:0]     mem_wdata_o;
  logic [WORD_BYTES-1:0] mem_be_o;
  logic [ID_W-1:0]       mem_id_o;
  logic                  mem_rtrn_vld_i;
  logic [ID_W-1:0]       mem_rtrn_id_i;
  logic                  empty_o;

  // next values for the falling edge
  logic                  st_req;
  logic                  st_ack;
  logic [ADDR_W-1:0]     st_addr;
  logic [DATA_W-1:0]     st_data;
  logic [WORD_BYTES-1:0] st_be;
  // outputs as seen at the last rising edge
  logic                  gnt_seen;
  logic                  mreq_seen;
  logic                  send_seen;
  logic [WORD_BYTES-1:0] be_seen;
  logic                  empty_seen;

  logic [31:0] lfsr_q;
  int          err_cnt;
  int          chk_cnt;
  int          cycle_cnt;

  `include "tb_wbuf_model.svh"

  wbuf_top #(
    .ADDR_W (ADDR_W),
    .DEPTH  (DEPTH),
    .MAX_TX (MAX_TX)
  ) i_wbuf_top (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_i          (req_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .gnt_o          (gnt_o),
    .mem_req_o      (mem_req_o),
    .mem_ack_i      (mem_ack_i),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_be_o       (mem_be_o),
    .mem_id_o       (mem_id_o),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .mem_rtrn_id_i  (mem_rtrn_id_i),
    .empty_o        (empty_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // random source and reporting
  ////////////////////////////////////////////////////////////

  // one Galois step per bit
  function automatic logic lfsr_step();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) lfsr_q = lfsr_q ^ LFSR_TAPS;
    return out;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[62:0], lfsr_step()};
    return v;
  endfunction

  task automatic log_mismatch(input string msg);
    err_cnt++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic raise_error(input string msg);
    err_cnt++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus, responder and per-cycle checks
  ////////////////////////////////////////////////////////////

  // store to one word of the window, nonzero byte enables
  task automatic new_store(input int widx);
    st_req  = 1'b1;
    st_addr = ADDR_W'((BASE_WORD + widx) * WORD_BYTES) | ADDR_W'(rand_bits(3));
    st_data = rand_bits(64);
    st_be   = WORD_BYTES'(rand_bits(8));
    if (st_be == '0) st_be = WORD_BYTES'(1) << rand_bits(3);
  endtask

  // return one ready ID, starting the search at a random slot
  task automatic drive_return();
    int  start;
    int  id;
    bit  found;
    start = int'(rand_bits(ID_W));
    found = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    for (int k = 0; k < MAX_TX; k++) begin
      id = (start + k) % MAX_TX;
      if (!found && out_vld[id] && out_due[id] == 0) begin
        found          = 1'b1;
        mem_rtrn_vld_i = 1'b1;
        mem_rtrn_id_i  = ID_W'(id);
      end
    end
    for (int k = 0; k < MAX_TX; k++) begin
      if (out_vld[k] && out_due[k] > 0) out_due[k]--;
    end
  endtask

  task automatic check_send(input int widx);
    if (mem_be_o == '0) log_mismatch("write sent with no byte enabled");
    if (out_vld[mem_id_o]) log_mismatch($sformatf("ID %0d sent while outstanding", mem_id_o));
    if (out_cnt >= MAX_TX) log_mismatch($sformatf("more than %0d writes outstanding", MAX_TX));
    if (widx < 0 || widx >= WORDS) begin
      raise_error($sformatf("write to word address %h outside the store window", mem_addr_o));
    end else begin
      if (word_busy(widx)) log_mismatch($sformatf("word %0d sent twice at once", widx));
      for (int j = 0; j < WORD_BYTES; j++) begin
        if (mem_be_o[j] && mem_wdata_o[j*8 +: 8] !== latest_q[widx][j]) begin
          log_mismatch($sformatf("word %0d byte %0d sent %h, expected %h",
                                 widx, j, mem_wdata_o[j*8 +: 8], latest_q[widx][j]));
        end
      end
    end
  endtask

  // drive at the falling edge, sample and update the model at the rising edge
  task automatic run_cycle();
    int widx;
    @(negedge clk_i);
    req_i     = st_req;
    addr_i    = st_addr;
    wdata_i   = st_data;
    be_i      = st_be;
    mem_ack_i = st_ack;
    drive_return();
    @(posedge clk_i);
    gnt_seen   = gnt_o;
    mreq_seen  = mem_req_o;
    send_seen  = mem_req_o && mem_ack_i;
    be_seen    = mem_be_o;
    empty_seen = empty_o;
    widx       = int'(mem_addr_o) - BASE_WORD;
    chk_cnt++;
    if (mem_req_o && out_cnt == MAX_TX) log_mismatch("write request with every ID outstanding");
    if (send_seen) check_send(widx);
    // a return frees its ID before this edge's send is booked
    if (mem_rtrn_vld_i) close_tx(int'(mem_rtrn_id_i));
    if (send_seen && widx >= 0 && widx < WORDS) begin
      open_tx(int'(mem_id_o), widx, mem_wdata_o, mem_be_o, int'(rand_bits(3)));
    end
    if (req_i && gnt_o) store_bytes(int'(addr_i[ADDR_W-1:3]) - BASE_WORD, wdata_i, be_i);
  endtask

  // no stores, random ack until every entry is gone
  task automatic drain_buffer();
    st_req     = 1'b0;
    empty_seen = 1'b0;
    while (!empty_seen) begin
      st_ack = lfsr_step();
      run_cycle();
    end
  endtask

  task automatic compare_image();
    for (int w = 0; w < WORDS; w++) begin
      for (int j = 0; j < WORD_BYTES; j++) begin
        if (written_q[w][j] && image_q[w][j] !== latest_q[w][j]) begin
          log_mismatch($sformatf("memory word %0d byte %0d is %h, expected %h",
                                 w, j, image_q[w][j], latest_q[w][j]));
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    bit pending;
    lfsr_q         = 32'd29;
    err_cnt        = 0;
    chk_cnt        = 0;
    out_cnt        = 0;
    tx_cnt         = 0;
    reset_i        = 1'b1;
    req_i          = 1'b0;
    addr_i         = '0;
    wdata_i        = '0;
    be_i           = '0;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_id_i  = '0;
    st_req         = 1'b0;
    st_ack         = 1'b0;
    st_addr        = '0;
    st_data        = '0;
    st_be          = '0;
    repeat (RESET_CYC) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // idle after reset
    run_cycle();
    if (mreq_seen || !empty_seen) begin
      log_mismatch($sformatf("after reset mem_req_o=%0b empty_o=%0b", mreq_seen, empty_seen));
    end

    // eight single-byte stores merge into one write
    st_ack = 1'b0;
    for (int j = 0; j < WORD_BYTES; j++) begin
      new_store(5);
      st_be = WORD_BYTES'(1) << j;
      run_cycle();
      if (!gnt_seen) log_mismatch($sformatf("byte %0d store to word 5 not granted", j));
    end
    st_req = 1'b0;
    st_ack = 1'b1;
    run_cycle();
    if (!send_seen || be_seen != {WORD_BYTES{1'b1}}) begin
      log_mismatch($sformatf("merged write sent=%0b be=%h", send_seen, be_seen));
    end
    drain_buffer();

    // fill every entry, then a new word must wait and a stored one must not
    st_ack = 1'b0;
    for (int w = 0; w < DEPTH; w++) begin
      new_store(w);
      run_cycle();
      if (!gnt_seen) log_mismatch($sformatf("store to word %0d not granted", w));
    end
    new_store(DEPTH);
    run_cycle();
    if (gnt_seen) log_mismatch("store to a new word granted with a full buffer");
    new_store(2);
    run_cycle();
    if (!gnt_seen) log_mismatch("store to a buffered word refused with a full buffer");
    drain_buffer();

    // random mix, a refused store is held until granted
    pending = 1'b0;
    for (int c = 0; c < RAND_CYC; c++) begin
      if (!pending) begin
        st_req = 1'b0;
        if (rand_bits(2) != 0) new_store(int'(rand_bits(4)) % WORDS);
      end
      st_ack = lfsr_step();
      run_cycle();
      pending = st_req && !gnt_seen;
    end
    drain_buffer();
    compare_image();

    $display("checks %0d, transactions %0d, errors %0d", chk_cnt, tx_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: project.f
+incdir+verif
common/wbuf_pkg.sv
hw/wbuf_rr_arbiter.sv
hw/entry_array/wbuf_entry_array.sv
hw/wbuf_tx_tracker.sv
hw/wbuf_top.sv
verif/tb_wbuf.sv

// File: Makefile
# Verilator build and run of the write buffer testbench

TOP = tb_wbuf

.PHONY: all compile run clean

all: run

# build the simulation binary from the file list
compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

# the log decides pass or fail, not the exit code of the binary
run: compile
	./obj_dir/V$(TOP) | tee run.log
	grep -q "TEST RESULT: PASS" run.log

clean:
	rm -rf obj_dir run.log
